//--- bt_bridge_pkg.sv
// ==============================
// Channel plus value fill exactly one 16-bit sample word
// Channel field limits the lane count to 8
// ==============================
`default_nettype none

package bt_bridge_pkg;

	localparam int chan_bits = 3;
	localparam int value_bits = 13;

	typedef logic [7:0] byte_t;

	// Same 16 bits, seen as sensor fields or as serial bytes
	typedef union packed
	{
		struct packed
		{
			logic [chan_bits-1:0] chan;
			logic [value_bits-1:0] value;
		} fields;
		struct packed
		{
			byte_t hi;
			byte_t lo;
		} bytes;
	} sample_word_u;

endpackage

`default_nettype wire

//--- uart_tx.sv
// ==============================
// 8N1, LSB first, cycles_per_bit of at least 2
// ==============================
`timescale 1ns/100ps
`default_nettype none

module uart_tx #(
	parameter int cycles_per_bit = 16
)(
	input logic clock,
	input logic reset,
	input logic tx_start,
	input bt_bridge_pkg::byte_t tx_byte,
	output logic tx_busy,
	output logic txd
);
	import bt_bridge_pkg::*;

	localparam int timer_bits = $clog2(cycles_per_bit);
	localparam logic [timer_bits-1:0] bit_end = timer_bits'(cycles_per_bit - 1);

	byte_t shift_reg;
	logic [timer_bits-1:0] timer;
	// 0 start, 1 to 8 data, 9 stop
	logic [3:0] bit_cnt;

	always_ff @(posedge clock)
	begin
		if (tx_start && !tx_busy)
			shift_reg <= tx_byte;
		else if (tx_busy && timer == bit_end && bit_cnt < 4'd8)
			shift_reg <= shift_reg >> 1;
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			tx_busy <= 1'b0;
			txd <= 1'b1;
			timer <= '0;
			bit_cnt <= '0;
		end
		else if (!tx_busy)
		begin
			if (tx_start)
			begin
				tx_busy <= 1'b1;
				txd <= 1'b0;
				timer <= '0;
				bit_cnt <= '0;
			end
		end
		else if (timer != bit_end)
			timer <= timer + 1'b1;
		else
		begin
			timer <= '0;
			if (bit_cnt == 4'd9)
				tx_busy <= 1'b0;
			else
			begin
				bit_cnt <= bit_cnt + 1'b1;
				txd <= (bit_cnt == 4'd8) ? 1'b1 : shift_reg[0];
			end
		end
	end

endmodule

`default_nettype wire

//--- stream_lane.sv
// ==============================
// Relies on distributor credits to never overflow
// ==============================
`timescale 1ns/100ps
`default_nettype none

module stream_lane #(
	parameter int lane_depth = 4
)(
	input logic clock,
	input logic reset,
	input logic push,
	input bt_bridge_pkg::sample_word_u push_word,
	input logic take,
	output logic byte_valid,
	output bt_bridge_pkg::byte_t byte_out,
	output logic byte_is_last,
	output logic credit_return
);
	import bt_bridge_pkg::*;

	localparam int ptr_bits = lane_depth > 1 ? $clog2(lane_depth) : 1;
	localparam int count_bits = $clog2(lane_depth + 1);
	localparam logic [ptr_bits-1:0] last_slot = ptr_bits'(lane_depth - 1);

	sample_word_u mem [lane_depth];
	sample_word_u head;
	logic [ptr_bits-1:0] wr_ptr;
	logic [ptr_bits-1:0] rd_ptr;
	logic [count_bits-1:0] count;
	logic lo_half;
	logic pop;

	assign head = mem[rd_ptr];
	assign byte_valid = count != '0;
	assign byte_out = lo_half ? head.bytes.lo : head.bytes.hi;
	assign byte_is_last = lo_half;

	// Word leaves only after its lo byte is taken
	assign pop = take && lo_half;

	always_ff @(posedge clock)
	begin
		if (push)
			mem[wr_ptr] <= push_word;
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			lo_half <= 1'b0;
			credit_return <= 1'b0;
		end
		else
		begin
			credit_return <= pop;
			if (push)
				wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
			if (take)
				lo_half <= !lo_half;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- sample_distributor.sv
// ==============================
// One credit counter per lane, starting at lane_depth
// Channels at or above num_lanes are dropped
// ==============================
`timescale 1ns/100ps
`default_nettype none

module sample_distributor #(
	parameter int num_lanes = 4,
	parameter int lane_depth = 4
)(
	input logic clock,
	input logic reset,
	input logic sample_valid,
	input bt_bridge_pkg::sample_word_u sample_word,
	output logic sample_ready,
	output logic sample_dropped,
	output logic [num_lanes-1:0] push,
	output bt_bridge_pkg::sample_word_u push_word,
	input logic [num_lanes-1:0] credit_return
);
	import bt_bridge_pkg::*;

	localparam int cnt_bits = $clog2(lane_depth + 1);
	localparam logic [cnt_bits-1:0] full_credit = cnt_bits'(lane_depth);
	localparam logic [cnt_bits-1:0] one_credit = cnt_bits'(1);

	logic [chan_bits-1:0] chan;
	logic chan_ok;
	logic accept;
	logic [num_lanes-1:0] lane_hit;
	logic [2**chan_bits-1:0] has_credit;
	logic [cnt_bits-1:0] credit [num_lanes];

	assign chan = sample_word.fields.chan;
	assign chan_ok = int'(chan) < num_lanes;

	// Unused channel slots read as no credit
	always_comb
	begin
		has_credit = '0;
		for (int i = 0; i < num_lanes; i++)
		begin
			has_credit[i] = credit[i] != '0;
			lane_hit[i] = int'(chan) == i;
		end
	end

	// Bad channels are always taken so they can be discarded
	assign sample_ready = !chan_ok || has_credit[chan];
	assign accept = sample_valid && sample_ready && chan_ok;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			push <= '0;
			sample_dropped <= 1'b0;
			for (int i = 0; i < num_lanes; i++)
			begin
				credit[i] <= full_credit;
			end
		end
		else
		begin
			push <= accept ? lane_hit : '0;
			sample_dropped <= sample_valid && !chan_ok;
			for (int i = 0; i < num_lanes; i++)
			begin
				// Take and return in the same cycle cancel out
				if (accept && lane_hit[i] && !credit_return[i])
					credit[i] <= credit[i] - one_credit;
				else if (credit_return[i] && !(accept && lane_hit[i]))
					credit[i] <= credit[i] + one_credit;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (accept)
			push_word <= sample_word;
	end

endmodule

`default_nettype wire

//--- tx_scheduler.sv
// ==============================
// Lanes must present the hi byte first, then the lo byte
// link_up only gates the start of a word
// ==============================
`timescale 1ns/100ps
`default_nettype none

module tx_scheduler #(
	parameter int num_lanes = 4
)(
	input logic clock,
	input logic reset,
	input logic link_up,
	input logic [num_lanes-1:0] byte_valid,
	input bt_bridge_pkg::byte_t [num_lanes-1:0] byte_in,
	input logic [num_lanes-1:0] byte_is_last,
	output logic [num_lanes-1:0] take,
	output logic tx_start,
	output bt_bridge_pkg::byte_t tx_byte,
	input logic tx_busy
);

	localparam int lane_bits = num_lanes > 1 ? $clog2(num_lanes) : 1;
	localparam logic [lane_bits-1:0] last_lane = lane_bits'(num_lanes - 1);

	logic locked;
	logic [lane_bits-1:0] cur;
	logic [lane_bits-1:0] rr_ptr;
	logic [lane_bits-1:0] pick;
	logic [lane_bits-1:0] sel;
	logic found;
	logic launch;

	// Round-robin search from rr_ptr
	always_comb
	begin
		int idx;
		found = 1'b0;
		pick = '0;
		for (int k = 0; k < num_lanes; k++)
		begin
			idx = (int'(rr_ptr) + k) % num_lanes;
			if (!found && byte_valid[idx])
			begin
				found = 1'b1;
				pick = lane_bits'(idx);
			end
		end
	end

	assign sel = locked ? cur : pick;

	// A started word finishes even after link_up drops
	assign launch = !tx_busy && (locked || (link_up && found));
	assign tx_start = launch;
	assign tx_byte = byte_in[sel];

	always_comb
	begin
		for (int i = 0; i < num_lanes; i++)
		begin
			take[i] = launch && int'(sel) == i;
		end
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			locked <= 1'b0;
			cur <= '0;
			rr_ptr <= '0;
		end
		else if (launch)
		begin
			if (byte_is_last[sel])
			begin
				locked <= 1'b0;
				rr_ptr <= (sel == last_lane) ? '0 : sel + 1'b1;
			end
			else
			begin
				locked <= 1'b1;
				cur <= sel;
			end
		end
	end

endmodule

`default_nettype wire

//--- bt_bridge_top.sv
// ==============================
// num_lanes up to 8, one word FIFO per lane
// Words go out hi byte first over one 8N1 line
// ==============================
`timescale 1ns/100ps
`default_nettype none

module bt_bridge_top #(
	parameter int num_lanes = 4,
	parameter int lane_depth = 4,
	parameter int cycles_per_bit = 16
)(
	input logic clock,
	input logic reset,
	input logic sample_valid,
	input bt_bridge_pkg::sample_word_u sample_word,
	output logic sample_ready,
	output logic sample_dropped,
	input logic link_up,
	output logic txd
);
	import bt_bridge_pkg::*;

	logic [num_lanes-1:0] push;
	sample_word_u push_word;
	logic [num_lanes-1:0] credit_return;
	logic [num_lanes-1:0] byte_valid;
	byte_t [num_lanes-1:0] lane_byte;
	logic [num_lanes-1:0] byte_is_last;
	logic [num_lanes-1:0] take;
	logic tx_start;
	byte_t tx_byte;
	logic tx_busy;

	sample_distributor #(
		.num_lanes(num_lanes),
		.lane_depth(lane_depth)
	) distributor (
		.clock(clock),
		.reset(reset),
		.sample_valid(sample_valid),
		.sample_word(sample_word),
		.sample_ready(sample_ready),
		.sample_dropped(sample_dropped),
		.push(push),
		.push_word(push_word),
		.credit_return(credit_return)
	);

	// One FIFO per sensor channel
	for (genvar i = 0; i < num_lanes; i++)
	begin : g_lane
		stream_lane #(
			.lane_depth(lane_depth)
		) lane (
			.clock(clock),
			.reset(reset),
			.push(push[i]),
			.push_word(push_word),
			.take(take[i]),
			.byte_valid(byte_valid[i]),
			.byte_out(lane_byte[i]),
			.byte_is_last(byte_is_last[i]),
			.credit_return(credit_return[i])
		);
	end

	tx_scheduler #(
		.num_lanes(num_lanes)
	) scheduler (
		.clock(clock),
		.reset(reset),
		.link_up(link_up),
		.byte_valid(byte_valid),
		.byte_in(lane_byte),
		.byte_is_last(byte_is_last),
		.take(take),
		.tx_start(tx_start),
		.tx_byte(tx_byte),
		.tx_busy(tx_busy)
	);

	uart_tx #(
		.cycles_per_bit(cycles_per_bit)
	) uart (
		.clock(clock),
		.reset(reset),
		.tx_start(tx_start),
		.tx_byte(tx_byte),
		.tx_busy(tx_busy),
		.txd(txd)
	);

endmodule

`default_nettype wire

//--- tb_bt_bridge.sv
// ==============================
// Built for 4 lanes of depth 4 and 8 clocks per UART bit
// txd is decoded by polling each clock at mid-bit
// ==============================
`timescale 1ns/100ps
`default_nettype none

module tb_bt_bridge;
	import bt_bridge_pkg::*;

	localparam int num_lanes = 4;
	localparam int lane_depth = 4;
	localparam int cycles_per_bit = 8;
	localparam int start_timeout = 4000;
	localparam int ready_timeout = 2000;

	logic clock;
	logic reset;
	logic sample_valid;
	sample_word_u sample_word;
	logic sample_ready;
	logic sample_dropped;
	logic link_up;
	logic txd;

	sample_word_u sent [num_lanes][lane_depth];

	bt_bridge_top #(
		.num_lanes(num_lanes),
		.lane_depth(lane_depth),
		.cycles_per_bit(cycles_per_bit)
	) uut (
		.clock(clock),
		.reset(reset),
		.sample_valid(sample_valid),
		.sample_word(sample_word),
		.sample_ready(sample_ready),
		.sample_dropped(sample_dropped),
		.link_up(link_up),
		.txd(txd)
	);

	initial
	begin
		clock = 1'b0;
		forever
		begin
			#50 clock = ~clock;
		end
	end

	task automatic check_equal(input int actual, input int expected, input string msg);
		if (actual != expected)
		begin
			$display("FAILED at %0t: %s (got 0x%0h, expected 0x%0h)",
				$time, msg, actual, expected);
			$display("TB FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("Timed out at %0t while waiting for %s", $time, what);
		$display("TB FAILED");
		$fatal(1, "timeout");
	endtask

	// Drive point is 5 ns after each rising edge
	task automatic next_cycle();
		@(posedge clock);
		#5;
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		sample_valid = 1'b0;
		sample_word = '0;
		link_up = 1'b0;
		repeat (10) @(posedge clock);
		#5;
		reset = 1'b0;
		next_cycle();
	endtask

	function automatic sample_word_u make_word(input int chan);
		sample_word_u w;
		w.fields.chan = chan_bits'(chan);
		w.fields.value = value_bits'($urandom);
		return w;
	endfunction

	task automatic send_sample(input sample_word_u w, input logic expect_drop);
		int waited;
		sample_valid = 1'b1;
		sample_word = w;
		waited = 0;
		#1;
		while (sample_ready !== 1'b1)
		begin
			if (waited >= ready_timeout)
				fail_timeout("sample_ready before a transfer");
			@(posedge clock);
			#1;
			waited++;
		end
		// Transfer edge
		next_cycle();
		sample_valid = 1'b0;
		check_equal(int'(sample_dropped), int'(expect_drop), "sample_dropped after transfer");
	endtask

	task automatic wait_ready(input int chan);
		int waited;
		sample_word = '0;
		sample_word.fields.chan = chan_bits'(chan);
		waited = 0;
		#1;
		while (sample_ready !== 1'b1)
		begin
			if (waited >= ready_timeout)
				fail_timeout("sample_ready to return");
			@(posedge clock);
			#1;
			waited++;
		end
		next_cycle();
	endtask

	task automatic receive_byte(output byte_t data, output int waited);
		waited = 0;
		while (txd !== 1'b0)
		begin
			if (waited >= start_timeout)
				fail_timeout("a start bit on txd");
			next_cycle();
			waited++;
		end
		repeat (cycles_per_bit / 2) next_cycle();
		check_equal(int'(txd), 0, "start bit at mid-bit");
		for (int i = 0; i < 8; i++)
		begin
			repeat (cycles_per_bit) next_cycle();
			data[i] = txd;
		end
		repeat (cycles_per_bit) next_cycle();
		check_equal(int'(txd), 1, "stop bit at mid-bit");
	endtask

	task automatic receive_word(output sample_word_u w);
		byte_t hi;
		byte_t lo;
		int waited;
		receive_byte(hi, waited);
		receive_byte(lo, waited);
		check_equal(int'(waited <= cycles_per_bit), 1, "lo byte right after its hi byte");
		w.bytes.hi = hi;
		w.bytes.lo = lo;
	endtask

	task automatic expect_idle(input int cycles, input string msg);
		for (int i = 0; i < cycles; i++)
		begin
			check_equal(int'(txd), 1, msg);
			next_cycle();
		end
	endtask

	task automatic test_idle_after_reset();
		apply_reset();
		link_up = 1'b1;
		#1;
		check_equal(int'(sample_ready), 1, "sample_ready after reset");
		next_cycle();
		expect_idle(40 * cycles_per_bit, "txd idle after reset");
	endtask

	task automatic test_single_word();
		sample_word_u w;
		sample_word_u rx;
		apply_reset();
		link_up = 1'b1;
		w = make_word(2);
		send_sample(w, 1'b0);
		receive_word(rx);
		check_equal(int'(rx.bytes.hi), int'(w.bytes.hi), "hi byte of channel 2 word");
		check_equal(int'(rx.bytes.lo), int'(w.bytes.lo), "lo byte of channel 2 word");
	endtask

	task automatic test_lane_fill();
		sample_word_u rx;
		apply_reset();
		for (int n = 0; n < lane_depth; n++)
		begin
			sent[1][n] = make_word(1);
			send_sample(sent[1][n], 1'b0);
		end
		// Credits for lane 1 are used up
		sample_word = '0;
		sample_word.fields.chan = 3'd1;
		#1;
		check_equal(int'(sample_ready), 0, "sample_ready with channel 1 full");
		next_cycle();
		sample_word.fields.chan = 3'd0;
		#1;
		check_equal(int'(sample_ready), 1, "sample_ready for channel 0");
		next_cycle();
		expect_idle(20 * cycles_per_bit, "txd idle while link is down");
		link_up = 1'b1;
		for (int n = 0; n < lane_depth; n++)
		begin
			receive_word(rx);
			check_equal(int'(rx), int'(sent[1][n]), "channel 1 word in order");
		end
		wait_ready(1);
	endtask

	task automatic test_round_robin();
		int order [6];
		sample_word_u rx;
		order = '{0, 1, 3, 0, 1, 3};
		apply_reset();
		for (int r = 0; r < 2; r++)
		begin
			for (int k = 0; k < 3; k++)
			begin
				sent[order[k]][r] = make_word(order[k]);
				send_sample(sent[order[k]][r], 1'b0);
			end
		end
		repeat (4) next_cycle();
		link_up = 1'b1;
		for (int k = 0; k < 6; k++)
		begin
			receive_word(rx);
			check_equal(int'(rx.fields.chan), order[k], "round-robin channel order");
			check_equal(int'(rx), int'(sent[order[k]][k / 3]), "round-robin word value");
		end
	endtask

	task automatic test_bad_channels();
		sample_word_u w;
		sample_word_u rx;
		apply_reset();
		link_up = 1'b1;
		for (int ch = 4; ch < 8; ch++)
		begin
			w = make_word(ch);
			send_sample(w, 1'b1);
			next_cycle();
			check_equal(int'(sample_dropped), 0, "sample_dropped lasts one cycle");
		end
		expect_idle(20 * cycles_per_bit, "txd idle after dropped samples");
		w = make_word(0);
		send_sample(w, 1'b0);
		receive_word(rx);
		check_equal(int'(rx), int'(w), "valid word after dropped samples");
	endtask

	initial
	begin
		reset = 1'b1;
		sample_valid = 1'b0;
		sample_word = '0;
		link_up = 1'b0;
		void'($urandom(32'h72a));
		test_idle_after_reset();
		test_single_word();
		test_lane_fill();
		test_round_robin();
		test_bad_channels();
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
bt_bridge_pkg.sv
uart_tx.sv
stream_lane.sv
sample_distributor.sv
tx_scheduler.sv
bt_bridge_top.sv
tb_bt_bridge.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, then judge the result from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/100ps --top-module tb_bt_bridge \
	-f sim.f -o tb_sim > sim.log 2>&1 \
	&& ./obj_dir/tb_sim >> sim.log 2>&1
cat sim.log
grep -q "TB FAILED" sim.log && echo "Simulation failed" && exit 1
grep -q "TB PASSED" sim.log && echo "Simulation passed" && exit 0
echo "Simulation did not complete" || true
exit 1
